/* common/decodePkg.sv */
package decodePkg;

    localparam int wordW    = 32;
    localparam int regAddrW = 6;
    localparam int excCodeW = 20;

    typedef logic [wordW-1:0]    word_t;
    typedef logic [regAddrW-1:0] regAddr_t;

    // logical numbers, hi and lo sit above the gprs.
    localparam regAddr_t regRa = 6'd31;
    localparam regAddr_t regHi = 6'd32;
    localparam regAddr_t regLo = 6'd33;

    // major opcodes seen by both decoder and target logic.
    localparam logic [5:0] opcSpecial = 6'h00;
    localparam logic [5:0] opcRegimm  = 6'h01;
    localparam logic [5:0] opcJ       = 6'h02;
    localparam logic [5:0] opcJal     = 6'h03;
    localparam logic [5:0] opcBeq     = 6'h04;
    localparam logic [5:0] opcBne     = 6'h05;
    localparam logic [5:0] opcBlez    = 6'h06;
    localparam logic [5:0] opcBgtz    = 6'h07;

    // mdu pairs keep hi and lo adjacent.
    typedef enum logic [5:0] {
        UOP_NONE,
        UOP_ADD, UOP_ADDU, UOP_SUB, UOP_SUBU, UOP_SLT, UOP_SLTU,
        UOP_ADDI, UOP_ADDIU, UOP_SLTI, UOP_SLTIU,
        UOP_AND, UOP_OR, UOP_XOR, UOP_NOR, UOP_ANDI, UOP_ORI, UOP_XORI, UOP_LUI,
        UOP_SLL, UOP_SRL, UOP_SRA, UOP_SLLV, UOP_SRLV, UOP_SRAV,
        UOP_BEQ, UOP_BNE, UOP_BLEZ, UOP_BGTZ, UOP_BLTZ, UOP_BGEZ, UOP_BLTZAL, UOP_BGEZAL,
        UOP_J, UOP_JAL, UOP_JR, UOP_JALR,
        UOP_MFHI, UOP_MFLO, UOP_MTHI, UOP_MTLO,
        UOP_MULTHI, UOP_MULTLO, UOP_MULTUHI, UOP_MULTULO,
        UOP_DIVHI, UOP_DIVLO, UOP_DIVUHI, UOP_DIVULO,
        UOP_LB, UOP_LH, UOP_LW, UOP_LBU, UOP_LHU, UOP_SB, UOP_SH, UOP_SW,
        UOP_SYSCALL, UOP_BREAK, UOP_RESERVED
    } uopOp_e;

    typedef enum logic [1:0] {
        UNIT_ALU,
        UNIT_MDU,
        UNIT_LSU
    } unitClass_e;

    typedef enum logic [2:0] {
        ALU_NONE,
        ALU_ARITH,
        ALU_LOGIC,
        ALU_SHIFT,
        ALU_BRANCH,
        ALU_MOVE,
        ALU_MISC
    } aluClass_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_COND,
        BR_JUMP,
        BR_JREG
    } branchKind_e;

    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_SEXT,
        IMM_ZEXT,
        IMM_UPPER,
        IMM_SHAMT
    } immKind_e;

    typedef enum logic [1:0] {
        EXC_NONE,
        EXC_SYSCALL,
        EXC_BREAK,
        EXC_RESERVED
    } excKind_e;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } instR_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } instI_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] index26;
    } instJ_t;

    typedef union packed {
        instR_t r;
        instI_t i;
        instJ_t j;
    } instWord_u;

    typedef struct packed {
        word_t     pc;
        instWord_u inst;
    } fetchInst_t;

    typedef struct packed {
        word_t                pc;
        uopOp_e               op;
        unitClass_e           unit;
        aluClass_e            aluClass;
        regAddr_t             src0;
        regAddr_t             src1;
        regAddr_t             dst;
        logic                 src0En;
        logic                 src1En;
        logic                 dstEn;
        word_t                imm;
        branchKind_e          branchKind;
        word_t                branchTarget;
        excKind_e             excKind;
        logic [excCodeW-1:0]  excCode;
    } uop_t;

    typedef struct packed {
        uop_t       uop0;
        uop_t       uop1;
        logic [1:0] count;
    } uopPair_t;

endpackage

/* decodeStage.f */
+incdir+tests
common/decodePkg.sv
design/decode/immGen.sv
design/decode/instDecoder.sv
design/instBuffer.sv
design/uopSplitter.sv
design/decodeStage.sv
tests/decodeStageTb.sv

/* design/decode/immGen.sv */
module immGen (
    input  decodePkg::fetchInst_t bufInst,
    input  decodePkg::immKind_e   immSel,
    output decodePkg::word_t      immValue,
    output decodePkg::word_t      branchTarget
);
    decodePkg::word_t pcPlus4;
    decodePkg::word_t sextImm;

    assign pcPlus4 = bufInst.pc + 32'd4;
    assign sextImm = {{16{bufInst.inst.i.imm16[15]}}, bufInst.inst.i.imm16};

    always_comb begin
        case (immSel)
            decodePkg::IMM_SEXT:  immValue = sextImm;
            decodePkg::IMM_ZEXT:  immValue = {16'h0, bufInst.inst.i.imm16};
            decodePkg::IMM_UPPER: immValue = {bufInst.inst.i.imm16, 16'h0};
            decodePkg::IMM_SHAMT: immValue = {27'h0, bufInst.inst.r.shamt};
            default:              immValue = '0;
        endcase
    end

    // jump register targets come from rs at execute.
    always_comb begin
        case (bufInst.inst.j.opcode)
            decodePkg::opcJ, decodePkg::opcJal: begin
                branchTarget = {pcPlus4[31:28], bufInst.inst.j.index26, 2'b00};
            end
            decodePkg::opcRegimm, decodePkg::opcBeq, decodePkg::opcBne,
            decodePkg::opcBlez, decodePkg::opcBgtz: begin
                branchTarget = pcPlus4 + {sextImm[29:0], 2'b00};
            end
            default: branchTarget = '0;
        endcase
    end

endmodule

/* design/decode/instDecoder.sv */
module instDecoder (
    input  decodePkg::fetchInst_t bufInst,
    input  decodePkg::word_t      immValue,
    input  decodePkg::word_t      branchTarget,
    output decodePkg::immKind_e   immSel,
    output decodePkg::uopPair_t   decPair
);
    decodePkg::instR_t   rView;
    decodePkg::instI_t   iView;
    decodePkg::regAddr_t rs;
    decodePkg::regAddr_t rt;
    decodePkg::regAddr_t rd;
    decodePkg::uopOp_e   op;
    decodePkg::uopOp_e   opLo;
    decodePkg::uop_t     base;
    logic [1:0]          count;

    // en is {src0En, src1En, dstEn}.
    function automatic decodePkg::uop_t setRegs(
        decodePkg::uop_t     u,
        logic [2:0]          en,
        decodePkg::regAddr_t s0,
        decodePkg::regAddr_t s1,
        decodePkg::regAddr_t d
    );
        u.src0En = en[2];
        u.src1En = en[1];
        u.dstEn  = en[0];
        u.src0   = s0;
        u.src1   = s1;
        u.dst    = d;
        return u;
    endfunction

    assign rView = bufInst.inst.r;
    assign iView = bufInst.inst.i;
    assign rs    = {1'b0, rView.rs};
    assign rt    = {1'b0, rView.rt};
    assign rd    = {1'b0, rView.rd};

    // opcode, funct and rt table.
    always_comb begin
        op   = decodePkg::UOP_RESERVED;
        opLo = decodePkg::UOP_NONE;
        case (iView.opcode)
            decodePkg::opcSpecial: begin
                case (rView.funct)
                    6'h00: op = decodePkg::UOP_SLL;
                    6'h02: op = decodePkg::UOP_SRL;
                    6'h03: op = decodePkg::UOP_SRA;
                    6'h04: op = decodePkg::UOP_SLLV;
                    6'h06: op = decodePkg::UOP_SRLV;
                    6'h07: op = decodePkg::UOP_SRAV;
                    6'h08: op = decodePkg::UOP_JR;
                    6'h09: op = decodePkg::UOP_JALR;
                    6'h0c: op = decodePkg::UOP_SYSCALL;
                    6'h0d: op = decodePkg::UOP_BREAK;
                    6'h10: op = decodePkg::UOP_MFHI;
                    6'h11: op = decodePkg::UOP_MTHI;
                    6'h12: op = decodePkg::UOP_MFLO;
                    6'h13: op = decodePkg::UOP_MTLO;
                    6'h18: begin
                        op   = decodePkg::UOP_MULTHI;
                        opLo = decodePkg::UOP_MULTLO;
                    end
                    6'h19: begin
                        op   = decodePkg::UOP_MULTUHI;
                        opLo = decodePkg::UOP_MULTULO;
                    end
                    6'h1a: begin
                        op   = decodePkg::UOP_DIVHI;
                        opLo = decodePkg::UOP_DIVLO;
                    end
                    6'h1b: begin
                        op   = decodePkg::UOP_DIVUHI;
                        opLo = decodePkg::UOP_DIVULO;
                    end
                    6'h20: op = decodePkg::UOP_ADD;
                    6'h21: op = decodePkg::UOP_ADDU;
                    6'h22: op = decodePkg::UOP_SUB;
                    6'h23: op = decodePkg::UOP_SUBU;
                    6'h24: op = decodePkg::UOP_AND;
                    6'h25: op = decodePkg::UOP_OR;
                    6'h26: op = decodePkg::UOP_XOR;
                    6'h27: op = decodePkg::UOP_NOR;
                    6'h2a: op = decodePkg::UOP_SLT;
                    6'h2b: op = decodePkg::UOP_SLTU;
                    default: ;
                endcase
            end
            decodePkg::opcRegimm: begin
                case (iView.rt)
                    5'h00: op = decodePkg::UOP_BLTZ;
                    5'h01: op = decodePkg::UOP_BGEZ;
                    5'h10: op = decodePkg::UOP_BLTZAL;
                    5'h11: op = decodePkg::UOP_BGEZAL;
                    default: ;
                endcase
            end
            decodePkg::opcJ:    op = decodePkg::UOP_J;
            decodePkg::opcJal:  op = decodePkg::UOP_JAL;
            decodePkg::opcBeq:  op = decodePkg::UOP_BEQ;
            decodePkg::opcBne:  op = decodePkg::UOP_BNE;
            decodePkg::opcBlez: op = decodePkg::UOP_BLEZ;
            decodePkg::opcBgtz: op = decodePkg::UOP_BGTZ;
            6'h08: op = decodePkg::UOP_ADDI;
            6'h09: op = decodePkg::UOP_ADDIU;
            6'h0a: op = decodePkg::UOP_SLTI;
            6'h0b: op = decodePkg::UOP_SLTIU;
            6'h0c: op = decodePkg::UOP_ANDI;
            6'h0d: op = decodePkg::UOP_ORI;
            6'h0e: op = decodePkg::UOP_XORI;
            6'h0f: op = decodePkg::UOP_LUI;
            6'h20: op = decodePkg::UOP_LB;
            6'h21: op = decodePkg::UOP_LH;
            6'h23: op = decodePkg::UOP_LW;
            6'h24: op = decodePkg::UOP_LBU;
            6'h25: op = decodePkg::UOP_LHU;
            6'h28: op = decodePkg::UOP_SB;
            6'h29: op = decodePkg::UOP_SH;
            6'h2b: op = decodePkg::UOP_SW;
            default: ;
        endcase
    end

    // class, operands and immediate form per micro-operation.
    always_comb begin
        base      = '0;
        base.pc   = bufInst.pc;
        base.op   = op;
        base.unit = decodePkg::UNIT_ALU;
        immSel    = decodePkg::IMM_NONE;
        case (op)
            decodePkg::UOP_ADD, decodePkg::UOP_ADDU, decodePkg::UOP_SUB,
            decodePkg::UOP_SUBU, decodePkg::UOP_SLT, decodePkg::UOP_SLTU: begin
                base.aluClass = decodePkg::ALU_ARITH;
                base          = setRegs(base, 3'b111, rs, rt, rd);
            end
            decodePkg::UOP_AND, decodePkg::UOP_OR, decodePkg::UOP_XOR,
            decodePkg::UOP_NOR: begin
                base.aluClass = decodePkg::ALU_LOGIC;
                base          = setRegs(base, 3'b111, rs, rt, rd);
            end
            decodePkg::UOP_ADDI, decodePkg::UOP_ADDIU, decodePkg::UOP_SLTI,
            decodePkg::UOP_SLTIU: begin
                base.aluClass = decodePkg::ALU_ARITH;
                base          = setRegs(base, 3'b101, rs, '0, rt);
                immSel        = decodePkg::IMM_SEXT;
            end
            decodePkg::UOP_ANDI, decodePkg::UOP_ORI, decodePkg::UOP_XORI: begin
                base.aluClass = decodePkg::ALU_LOGIC;
                base          = setRegs(base, 3'b101, rs, '0, rt);
                immSel        = decodePkg::IMM_ZEXT;
            end
            decodePkg::UOP_LUI: begin
                base.aluClass = decodePkg::ALU_LOGIC;
                base          = setRegs(base, 3'b001, '0, '0, rt);
                immSel        = decodePkg::IMM_UPPER;
            end
            decodePkg::UOP_SLL, decodePkg::UOP_SRL, decodePkg::UOP_SRA: begin
                base.aluClass = decodePkg::ALU_SHIFT;
                base          = setRegs(base, 3'b101, rt, '0, rd);
                immSel        = decodePkg::IMM_SHAMT;
            end
            // shift amount comes from rs here.
            decodePkg::UOP_SLLV, decodePkg::UOP_SRLV, decodePkg::UOP_SRAV: begin
                base.aluClass = decodePkg::ALU_SHIFT;
                base          = setRegs(base, 3'b111, rt, rs, rd);
            end
            decodePkg::UOP_BEQ, decodePkg::UOP_BNE: begin
                base.aluClass   = decodePkg::ALU_BRANCH;
                base.branchKind = decodePkg::BR_COND;
                base            = setRegs(base, 3'b110, rs, rt, '0);
            end
            decodePkg::UOP_BLEZ, decodePkg::UOP_BGTZ, decodePkg::UOP_BLTZ,
            decodePkg::UOP_BGEZ: begin
                base.aluClass   = decodePkg::ALU_BRANCH;
                base.branchKind = decodePkg::BR_COND;
                base            = setRegs(base, 3'b100, rs, '0, '0);
            end
            decodePkg::UOP_BLTZAL, decodePkg::UOP_BGEZAL: begin
                base.aluClass   = decodePkg::ALU_BRANCH;
                base.branchKind = decodePkg::BR_COND;
                base            = setRegs(base, 3'b101, rs, '0, decodePkg::regRa);
            end
            decodePkg::UOP_J, decodePkg::UOP_JAL: begin
                base.aluClass   = decodePkg::ALU_BRANCH;
                base.branchKind = decodePkg::BR_JUMP;
                if (op == decodePkg::UOP_JAL) begin
                    base = setRegs(base, 3'b001, '0, '0, decodePkg::regRa);
                end
            end
            decodePkg::UOP_JR, decodePkg::UOP_JALR: begin
                base.aluClass   = decodePkg::ALU_BRANCH;
                base.branchKind = decodePkg::BR_JREG;
                base            = setRegs(base, {2'b10, op == decodePkg::UOP_JALR}, rs, '0,
                                          (op == decodePkg::UOP_JALR) ? rd : '0);
            end
            decodePkg::UOP_MFHI, decodePkg::UOP_MFLO: begin
                base.aluClass = decodePkg::ALU_MOVE;
                base          = setRegs(base, 3'b101, (op == decodePkg::UOP_MFHI) ?
                                        decodePkg::regHi : decodePkg::regLo, '0, rd);
            end
            decodePkg::UOP_MTHI, decodePkg::UOP_MTLO: begin
                base.aluClass = decodePkg::ALU_MOVE;
                base          = setRegs(base, 3'b101, rs, '0, (op == decodePkg::UOP_MTHI) ?
                                        decodePkg::regHi : decodePkg::regLo);
            end
            decodePkg::UOP_MULTHI, decodePkg::UOP_MULTUHI, decodePkg::UOP_DIVHI,
            decodePkg::UOP_DIVUHI: begin
                base.unit = decodePkg::UNIT_MDU;
                base      = setRegs(base, 3'b111, rs, rt, decodePkg::regHi);
            end
            decodePkg::UOP_LB, decodePkg::UOP_LH, decodePkg::UOP_LW,
            decodePkg::UOP_LBU, decodePkg::UOP_LHU: begin
                base.unit = decodePkg::UNIT_LSU;
                base      = setRegs(base, 3'b101, rs, '0, rt);
                immSel    = decodePkg::IMM_SEXT;
            end
            decodePkg::UOP_SB, decodePkg::UOP_SH, decodePkg::UOP_SW: begin
                base.unit = decodePkg::UNIT_LSU;
                base      = setRegs(base, 3'b110, rs, rt, '0);
                immSel    = decodePkg::IMM_SEXT;
            end
            decodePkg::UOP_SYSCALL, decodePkg::UOP_BREAK: begin
                base.aluClass = decodePkg::ALU_MISC;
                base.excKind  = (op == decodePkg::UOP_SYSCALL) ?
                                decodePkg::EXC_SYSCALL : decodePkg::EXC_BREAK;
                base.excCode  = {rView.rs, rView.rt, rView.rd, rView.shamt};
            end
            default: begin
                base.aluClass = decodePkg::ALU_MISC;
                base.excKind  = decodePkg::EXC_RESERVED;
            end
        endcase
    end

    // the all-zero word emits nothing.
    assign count = (rView == '0) ? 2'd0 :
                   (opLo != decodePkg::UOP_NONE) ? 2'd2 : 2'd1;

    always_comb begin
        decPair       = '0;
        decPair.count = count;
        if (count != 2'd0) begin
            decPair.uop0     = base;
            decPair.uop0.imm = immValue;
            if (base.branchKind != decodePkg::BR_NONE) begin
                decPair.uop0.branchTarget = branchTarget;
            end
        end
        // lo half repeats the sources.
        if (count == 2'd2) begin
            decPair.uop1     = base;
            decPair.uop1.op  = opLo;
            decPair.uop1.dst = decodePkg::regLo;
        end
    end

endmodule

/* design/decodeStage.sv */
module decodeStage (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  inValid,
    output logic                  inReady,
    input  decodePkg::fetchInst_t inInst,
    output logic                  outValid,
    input  logic                  outReady,
    output decodePkg::uop_t       outUop
);
    logic                  bufValid;
    logic                  bufTake;
    decodePkg::fetchInst_t bufInst;
    decodePkg::uopPair_t   decPair;
    decodePkg::immKind_e   immSel;
    decodePkg::word_t      immValue;
    decodePkg::word_t      branchTarget;

    instBuffer uInstBuffer (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (inValid),
        .inInst   (inInst),
        .inReady  (inReady),
        .bufValid (bufValid),
        .bufInst  (bufInst),
        .bufTake  (bufTake)
    );

    instDecoder uInstDecoder (
        .bufInst      (bufInst),
        .immValue     (immValue),
        .branchTarget (branchTarget),
        .immSel       (immSel),
        .decPair      (decPair)
    );

    immGen uImmGen (
        .bufInst      (bufInst),
        .immSel       (immSel),
        .immValue     (immValue),
        .branchTarget (branchTarget)
    );

    uopSplitter uUopSplitter (
        .clk      (clk),
        .arstN    (arstN),
        .bufValid (bufValid),
        .decPair  (decPair),
        .bufTake  (bufTake),
        .outValid (outValid),
        .outUop   (outUop),
        .outReady (outReady)
    );

endmodule

/* design/instBuffer.sv */
module instBuffer (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  inValid,
    input  decodePkg::fetchInst_t inInst,
    output logic                  inReady,
    output logic                  bufValid,
    output decodePkg::fetchInst_t bufInst,
    input  logic                  bufTake
);

    // refill in the same cycle the entry moves on.
    assign inReady = !bufValid || bufTake;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            bufValid <= 1'b0;
        end else if (inReady) begin
            bufValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            bufInst <= inInst;
        end
    end

endmodule

/* design/uopSplitter.sv */
module uopSplitter (
    input  logic                clk,
    input  logic                arstN,
    input  logic                bufValid,
    input  decodePkg::uopPair_t decPair,
    output logic                bufTake,
    output logic                outValid,
    output decodePkg::uop_t     outUop,
    input  logic                outReady
);
    decodePkg::uopPair_t pair;
    logic [1:0]          left;
    logic                outFire;
    logic                lastOut;

    assign outValid = left != 2'd0;
    assign outFire  = outValid && outReady;
    assign lastOut  = outFire && left == 2'd1;
    assign bufTake  = bufValid && (!outValid || lastOut);

    // lo half of a pair once one is left.
    assign outUop = (pair.count == 2'd2 && left == 2'd1) ? pair.uop1 : pair.uop0;

    // a count of zero loads and leaves at once.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            left <= 2'd0;
        end else if (bufTake) begin
            left <= decPair.count;
        end else if (outFire) begin
            left <= left - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (bufTake) begin
            pair <= decPair;
        end
    end

endmodule

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module decodeStageTb -f decodeStage.f -o decodeSim &&
./obj_dir/decodeSim | tee /dev/stderr | grep -q "TESTS PASSED" &&
echo "run.sh: simulation ok" ||
{ echo "run.sh: simulation failed"; exit 1; }

/* tests/decodeChecks.svh */
// micro-operation compare, whole word.
task automatic checkUop(
    input string           name,
    input decodePkg::uop_t expected,
    input decodePkg::uop_t actual
);
    if (actual !== expected) begin
        $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
        $display("TESTS FAILED");
        $fatal(1, "micro-operation mismatch");
    end
endtask

// number of micro-operations one instruction produced.
task automatic checkCount(
    input string      name,
    input logic [1:0] expected,
    input logic [1:0] actual
);
    if (actual !== expected) begin
        $display("[FAIL] %s count: expected %0d, actual %0d", name, expected, actual);
        $display("TESTS FAILED");
        $fatal(1, "micro-operation count mismatch");
    end
endtask

/* tests/decodeStageTb.sv */
module decodeStageTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int numTests    = 29;
    localparam int lineWords   = 6;
    localparam int resetCycles = 16;
    localparam int passes      = 2;
    localparam int drainLimit  = 40;
    localparam int cycleLimit  = resetCycles + 10 * numTests * passes;

    logic                  clk;
    logic                  arstN;
    logic                  inValid;
    logic                  inReady;
    decodePkg::fetchInst_t inInst;
    logic                  outValid;
    logic                  outReady;
    decodePkg::uop_t       outUop;

    logic [119:0]     testMem [0:numTests*lineWords-1];
    decodePkg::uop_t  expQ[$];
    int               tagQ[$];
    logic [1:0]       expCount [0:numTests];
    int               grpTag;
    logic [1:0]       grpSeen;
    decodePkg::word_t grpPc;
    int               curIdx;
    int               cycles;
    int               seed;
    bit               randomReady;

    `include "decodeChecks.svh"

    decodeStage uut (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (inValid),
        .inReady  (inReady),
        .inInst   (inInst),
        .outValid (outValid),
        .outReady (outReady),
        .outUop   (outUop)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // back-pressure only in the random pass.
    initial begin
        forever begin
            @(negedge clk);
            if (randomReady) begin
                outReady = ($random(seed) & 1) != 0;
            end else begin
                outReady = 1'b1;
            end
        end
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= cycleLimit) begin
                $display("timeout: the decode stage stopped producing micro-operations");
                $display("TESTS FAILED");
                $fatal(1, "cycle limit reached");
            end
        end
    end

    // scoreboard on both handshakes.
    initial begin : monitor
        decodePkg::uop_t e;
        decodePkg::uop_t heldUop;
        decodePkg::word_t pc;
        bit stalled;
        int tag;
        int heldTag;
        int base;
        stalled = 1'b0;
        heldTag = 0;
        forever begin
            @(posedge clk);
            if (stalled) begin
                if (!outValid) begin
                    $display("outValid dropped while the output was stalled");
                    $display("TESTS FAILED");
                    $fatal(1, "stall violation");
                end
                checkUop($sformatf("test %0d stall", heldTag), heldUop, outUop);
            end
            stalled = outValid && !outReady;
            heldUop = outUop;
            heldTag = (tagQ.size() != 0) ? tagQ[0] : 0;
            if (outValid && outReady) begin
                if (expQ.size() == 0) begin
                    $display("the stage produced a micro-operation that was not expected");
                    $display("TESTS FAILED");
                    $fatal(1, "unexpected output");
                end
                // a new pc closes the previous instruction.
                if (grpSeen != 2'd0 && outUop.pc != grpPc) begin
                    checkCount($sformatf("test %0d", grpTag), expCount[grpTag], grpSeen);
                    grpSeen = 2'd0;
                end
                e   = expQ.pop_front();
                tag = tagQ.pop_front();
                checkUop($sformatf("test %0d", tag), e, outUop);
                if (grpSeen == 2'd0) begin
                    grpTag = tag;
                    grpPc  = outUop.pc;
                end
                grpSeen = grpSeen + 2'd1;
            end
            if (arstN && inValid && inReady) begin
                base = curIdx * lineWords;
                tag  = int'(testMem[base][7:0]);
                pc   = testMem[base+1][31:0];
                expCount[tag] = testMem[base+3][1:0];
                if (testMem[base+3][1:0] != 2'd0) begin
                    e = {pc, testMem[base+4]};
                    expQ.push_back(e);
                    tagQ.push_back(tag);
                end
                if (testMem[base+3][1:0] == 2'd2) begin
                    e = {pc, testMem[base+5]};
                    expQ.push_back(e);
                    tagQ.push_back(tag);
                end
            end
        end
    end

    task automatic sendTest(input int idx);
        decodePkg::fetchInst_t f;
        f.pc   = testMem[idx*lineWords+1][31:0];
        f.inst = testMem[idx*lineWords+2][31:0];
        @(negedge clk);
        curIdx  = idx;
        inValid = 1'b1;
        inInst  = f;
        @(posedge clk);
        while (!inReady) begin
            @(posedge clk);
        end
    endtask

    task automatic drainAndCount();
        int idle;
        idle = 0;
        while (expQ.size() != 0 && idle < drainLimit) begin
            @(negedge clk);
            idle++;
        end
        // the last instruction has no successor to close it.
        if (expQ.size() == 0 && grpSeen != 2'd0) begin
            checkCount($sformatf("test %0d", grpTag), expCount[grpTag], grpSeen);
            grpSeen = 2'd0;
        end
    endtask

    initial begin : mainFlow
        int p;
        int i;
        seed        = 32'h78d3_65d6;
        arstN       = 1'b0;
        inValid     = 1'b0;
        inInst      = '0;
        outReady    = 1'b1;
        randomReady = 1'b0;
        curIdx      = 0;
        grpTag      = 0;
        grpSeen     = 2'd0;
        grpPc       = '0;
        for (i = 0; i <= numTests; i++) begin
            expCount[i] = 2'd0;
        end
        $readmemh("tests/decodeTests.mem", testMem);
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        // second pass replays the table under random outReady.
        for (p = 0; p < passes; p++) begin
            randomReady = (p == 1);
            for (i = 0; i < numTests; i++) begin
                sendTest(i);
            end
            @(negedge clk);
            inValid = 1'b0;
            drainAndCount();
            randomReady = 1'b0;
            if (expQ.size() != 0) begin
                break;
            end
        end
        if (expQ.size() != 0) begin
            $display("%0d micro-operations were lost", expQ.size());
            $display("TESTS FAILED");
            $fatal(1, "lost micro-operations");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

/* tests/decodeTests.mem */
// hex columns: test, pc, instruction, count, uop0, uop1
// uop without pc: {op..enables}_imm_{branchKind, branchTarget, excKind, excCode}
01 00400004 00221820 1 0420841F_00000000_00000000000000 0
02 00400008 00221823 1 1020841F_00000000_00000000000000 0
03 0040000C 0022182A 1 1420841F_00000000_00000000000000 0
04 00400010 00221824 1 2C40841F_00000000_00000000000000 0
05 00400014 00221827 1 3840841F_00000000_00000000000000 0
06 00400018 00221804 1 5861021F_00000000_00000000000000 0
07 0040001C 00021943 1 5461001D_00000005_00000000000000 0
08 00400020 2022FFFC 1 1C208015_FFFFFFFC_00000000000000 0
09 00400024 2C228000 1 28208015_FFFF8000_00000000000000 0
0A 00400028 30228001 1 3C408015_00008001_00000000000000 0
0B 0040002C 3422F0F0 1 40408015_0000F0F0_00000000000000 0
0C 00400030 3C021234 1 48400011_12340000_00000000000000 0
0D 00400034 8C22FFF8 1 CE008015_FFFFFFF8_00000000000000 0
0E 00400038 A0220010 1 DA008406_00000010_00000000000000 0
0F 0040003C 00220018 2 A5008507_00000000_00000000000000 A900850F_00000000_00000000000000
10 00400040 00220019 2 AD008507_00000000_00000000000000 B100850F_00000000_00000000000000
11 00400044 0022001A 2 B5008507_00000000_00000000000000 B900850F_00000000_00000000000000
12 00400048 0022001B 2 BD008507_00000000_00000000000000 C100850F_00000000_00000000000000
13 0040004C 00000000 0 0 0
14 00400050 10220003 1 64808406_00000000_40100018000000 0
15 00400054 0431FFFE 1 808080FD_00000000_40100014000000 0
16 BFC00058 08100020 1 84800000_00000000_AC100020000000 0
17 0040005C 0C100100 1 888000F9_00000000_80100100000000 0
18 00400060 00200008 1 8C808004_00000000_C0000000000000 0
19 00400064 00201809 1 9080801D_00000000_C0000000000000 0
1A 00400068 0048D14C 1 E4C00000_00000000_00000000112345 0
1B 0040006C 03FFFFCD 1 E8C00000_00000000_000000002FFFFF 0
1C 00400070 FC000000 1 ECC00000_00000000_00000000300000 0
1D 00400074 00001812 1 98B0801D_00000000_00000000000000 0
